//--- Makefile
VERILATOR = verilator
TOP       = cacheTop_tb
FILELIST  = compile.f
OBJDIR    = obj_dir
VFLAGS    = --binary --timing --assert -Wno-fatal --top-module $(TOP) -Mdir $(OBJDIR)

SIM     = $(OBJDIR)/V$(TOP)
SOURCES = $(wildcard src/*.sv src/*.svh sim/*.sv)

.PHONY: all run clean

all: $(SIM)

# rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST)

# pass only when the simulation prints the pass line
run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "TB PASSED"

clean:
	rm -rf $(OBJDIR)

//--- compile.f
+incdir+src
src/cacheTypesPkg.sv
src/cacheCtrlPkg.sv
src/dataArray.sv
src/metaDataArray.sv
src/cacheData.sv
src/missFsm.sv
src/mainMemory.sv
src/cacheTop.sv
sim/cacheTop_checker.sv
sim/cacheTop_tb.sv

//--- sim/cacheTop_checker.sv
`timescale 1ns/1ps
`default_nettype none

module cacheTop_checker (
  input wire clk,
  input wire reset,
  input wire dataWe,       // refill word strobe
  input wire metaWe,       // refill tag strobe
  input wire stallD,       // pending metadata stall
  input wire miss,
  input wire fillActive
);

  int assertFails = 0;     // read by the testbench at the end

  // WRITE and META are separate fsm states
  strobesExclusive: assert property (@(posedge clk) disable iff (reset)
    !(dataWe && metaWe))
    else begin
      assertFails++;
      $error("dataWe and metaWe high in the same cycle");
    end

  // the metadata write lands one cycle after it was loaded
  stallOneCycle: assert property (@(posedge clk) disable iff (reset)
    stallD |=> !stallD)
    else begin
      assertFails++;
      $error("stallD held for more than one cycle");
    end

  // request keeps missing from REQ up to and including META
  fillMeansMiss: assert property (@(posedge clk) disable iff (reset)
    fillActive |-> miss)
    else begin
      assertFails++;
      $error("fillActive high while miss is low");
    end

endmodule

`default_nettype wire

//--- sim/cacheTop_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "cache_macros.svh"

module cacheTop_tb;

  import cacheTypesPkg::*;

  localparam int TIMEOUT_CYCLES = 200;  // a refill needs well under 70
  localparam int RANDOM_OPS     = 40;

  logic clk;
  logic reset;
  addrT addrCpu;
  wordT dataInCpu;
  logic read;
  logic write;
  wordT dataOutCpu;
  logic busy;
  logic fillActive;

  // operation table with one entry per cpu request
  string opName  [$];
  bit    opWrite [$];
  addrT  opAddr  [$];
  wordT  opData  [$];
  bit    opFill  [$];                   // refill expected

  wordT refMem [`MEM_WORDS];            // expected backing memory
  tagT  modelTag   [`NUM_SETS][2];      // two-way lru model
  bit   modelValid [`NUM_SETS][2];
  bit   leftMru    [`NUM_SETS];         // left way used last

  int seed = 38863;

  cacheTop dut (
    .clk(clk), .reset(reset), .addrCpu(addrCpu), .dataInCpu(dataInCpu),
    .read(read), .write(write), .dataOutCpu(dataOutCpu), .busy(busy),
    .fillActive(fillActive)
  );

  bind cacheTop cacheTop_checker protocolChecks (
    .clk(clk), .reset(reset), .dataWe(dataWe), .metaWe(metaWe),
    .stallD(stallD), .miss(miss), .fillActive(fillActive)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;                // 10 ns period
  end

  //////////////////////////////////////////////////////////////////////
  // table helpers
  //////////////////////////////////////////////////////////////////////
  function automatic addrT makeAddr(input int tag, input int set, input int off);
    return {tag[`TAG_W-1:0], set[`SET_W-1:0], off[`OFF_W-1:0], 1'b0};
  endfunction

  task automatic addOp(input string name, input bit wr, input addrT addr,
                       input wordT data, input bit fill);
    opName.push_back(name);
    opWrite.push_back(wr);
    opAddr.push_back(addr);
    opData.push_back(data);
    opFill.push_back(fill);
  endtask

  // 1 when the access needs a refill; replaces left unless left used last
  function automatic bit predictRefill(input addrT addr);
    tagT t;
    int  s;
    int  way;
    bit  refill;
    t      = addr[`ADDR_W-1 -: `TAG_W];
    s      = addr[`OFF_W+1 +: `SET_W];
    refill = 1'b0;
    if (modelValid[s][0] && modelTag[s][0] == t) begin
      way = 0;
    end else if (modelValid[s][1] && modelTag[s][1] == t) begin
      way = 1;
    end else begin
      refill = 1'b1;
      way    = leftMru[s] ? 1 : 0;
      modelValid[s][way] = 1'b1;
      modelTag[s][way]   = t;
    end
    leftMru[s] = (way == 0);
    return refill;
  endfunction

  task automatic buildTable();
    int   r;
    addrT addr;
    wordT data;
    addOp("cold miss", 1'b0, makeAddr(1, 1, 0), '0, 1'b1);
    addOp("warm hit", 1'b0, makeAddr(1, 1, 5), '0, 1'b0);
    addOp("warm hit", 1'b0, makeAddr(1, 1, 7), '0, 1'b0);
    addOp("warm hit", 1'b0, makeAddr(1, 1, 0), '0, 1'b0);
    // write hit then two other tags push the block out
    addOp("write hit", 1'b1, makeAddr(1, 1, 3), 16'hBEEF, 1'b0);
    addOp("write hit reread", 1'b0, makeAddr(1, 1, 3), '0, 1'b0);
    addOp("evict fill right", 1'b0, makeAddr(2, 1, 0), '0, 1'b1);
    addOp("evict left", 1'b0, makeAddr(3, 1, 4), '0, 1'b1);
    addOp("written word via memory", 1'b0, makeAddr(1, 1, 3), '0, 1'b1);
    // tags A B C in set 2
    addOp("lru fill A", 1'b0, makeAddr(4, 2, 2), '0, 1'b1);
    addOp("lru fill B", 1'b0, makeAddr(5, 2, 2), '0, 1'b1);
    addOp("lru fill C", 1'b0, makeAddr(6, 2, 2), '0, 1'b1);
    addOp("lru B kept", 1'b0, makeAddr(5, 2, 6), '0, 1'b0);
    addOp("lru A evicted", 1'b0, makeAddr(4, 2, 1), '0, 1'b1);
    // hits back to back with a stall before each one
    addOp("b2b fill", 1'b0, makeAddr(7, 3, 0), '0, 1'b1);
    addOp("b2b write", 1'b1, makeAddr(7, 3, 1), 16'h1234, 1'b0);
    addOp("b2b read", 1'b0, makeAddr(7, 3, 1), '0, 1'b0);
    addOp("b2b read", 1'b0, makeAddr(7, 3, 2), '0, 1'b0);
    addOp("b2b write", 1'b1, makeAddr(7, 3, 2), 16'h5678, 1'b0);
    addOp("b2b read", 1'b0, makeAddr(7, 3, 2), '0, 1'b0);
    addOp("b2b read", 1'b0, makeAddr(7, 3, 1), '0, 1'b0);
    // four tags over sets 40 and 41 so evictions happen
    for (int n = 0; n < RANDOM_OPS; n++) begin
      r    = $random(seed);
      addr = makeAddr(8 + r[1:0], 40 + r[2], r[5:3]);
      data = wordT'($random(seed));
      addOp("random mix", r[6], addr, data, predictRefill(addr));
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // checking and request handling
  //////////////////////////////////////////////////////////////////////
  task automatic checkValue(input string name, input logic [31:0] expected,
                            input logic [31:0] actual);
    if (expected !== actual) begin
      $display("Fail %s: expected %0h, actual %0h", name, expected, actual);
      $display("TB FAILED");
      $fatal(1, "stopping at the first mismatch");
    end
  endtask

  task automatic applyOp(input int i);
    int   cycles;
    int   fills;
    bit   done;
    bit   fillPrev;
    wordT got;
    cycles    = 0;
    fills     = 0;
    done      = 1'b0;
    got       = '0;
    fillPrev  = fillActive;
    read      = ~opWrite[i];
    write     = opWrite[i];
    addrCpu   = opAddr[i];
    dataInCpu = opData[i];
    while (!done && cycles < TIMEOUT_CYCLES) begin
      @(negedge clk);                     // outputs settled here
      if (fillActive && !fillPrev) begin
        fills++;
      end
      fillPrev = fillActive;
      if (!busy) begin
        done = 1'b1;                      // completes at the next edge
        got  = dataOutCpu;
      end
      cycles++;
      @(posedge clk);
      #1;
    end
    if (!done) begin
      $display("request %0d (%s) never completed, busy stayed high", i, opName[i]);
      $display("TB FAILED");
      $fatal(1, "request timeout");
    end else begin
      checkValue({opName[i], " refill count"}, opFill[i], fills);
      if (opWrite[i]) begin
        refMem[opAddr[i][`ADDR_W-1:1]] = opData[i];   // write-through
      end else begin
        checkValue({opName[i], " read data"}, refMem[opAddr[i][`ADDR_W-1:1]], got);
      end
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////////////////////////
  initial begin
    reset     = 1'b1;
    read      = 1'b0;
    write     = 1'b0;
    addrCpu   = '0;
    dataInCpu = '0;
    for (int w = 0; w < `MEM_WORDS; w++) begin
      refMem[w] = wordT'(w);              // memory starts at its word address
    end
    buildTable();
    repeat (3) @(posedge clk);
    #1;
    reset = 1'b0;
    for (int i = 0; i < opName.size(); i++) begin
      applyOp(i);
    end
    read  = 1'b0;
    write = 1'b0;
    repeat (3) @(posedge clk);            // let the checker see the tail
    if (dut.protocolChecks.assertFails == 0) begin
      $display("TB PASSED");
    end else begin
      $display("%0d protocol assertion failures", dut.protocolChecks.assertFails);
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- src/cacheCtrlPkg.sv
`default_nettype none

`include "cache_macros.svh"

// types for the refill controller
package cacheCtrlPkg;

  typedef enum logic [2:0] {
    IDLE,   // waiting for a miss
    REQ,    // memory read strobe
    WAIT,   // waiting for memValid
    WRITE,  // word into data array
    META,   // new tag into metadata
    DONE    // metadata write lands
  } fillStateT;

  typedef logic [`OFF_W-1:0] wordCountT;   // word within the block

endpackage

`default_nettype wire

//--- src/cacheData.sv
`timescale 1ns/1ps
`default_nettype none

`include "cache_macros.svh"

module cacheData (
  input  wire                 clk,
  input  wire                 reset,
  input  wire cacheTypesPkg::addrT addrCpu,    // cpu request address
  input  wire cacheTypesPkg::addrT addrFsm,    // refill word address
  input  wire cacheTypesPkg::wordT dataInCpu,  // write hit data
  input  wire cacheTypesPkg::wordT dataInFsm,  // refill data
  input  wire                 read,
  input  wire                 write,
  input  wire                 metaWe,          // refill metadata strobe
  input  wire                 dataWe,          // refill data strobe
  output cacheTypesPkg::wordT dataOutCpu,
  output logic                miss,            // level to the fsm
  output logic                stallD           // one-cycle metadata stall
);

  import cacheTypesPkg::*;

  tagT     tag;
  setT     set;
  offsetT  offCpu;
  offsetT  offFsm;
  blockEnT setEn;
  blockEnT stalledEn;
  blockEnT metaEn;
  wordEnT  cpuWordEn;
  wordEnT  fsmWordEn;

  wordT    dataOutL;
  wordT    dataOutR;
  wordT    dataInL;
  wordT    dataInR;
  wordEnT  wordEnL;
  wordEnT  wordEnR;
  logic    dataWriteL;
  logic    dataWriteR;

  metaT    metaOutL;
  metaT    metaOutR;
  metaT    curMetaL;
  metaT    curMetaR;
  metaT    metaNewL;
  metaT    metaNewR;
  metaT    metaRegL;
  metaT    metaRegR;
  setT     setStalled;
  logic    metaPend;
  logic    metaLoad;

  logic    req;
  logic    known;
  logic    matchL;
  logic    matchR;
  logic    hitL;
  logic    hitR;
  logic    goLeft;

  //////////////////////////////////////////////////////////////////////
  // address decode
  //////////////////////////////////////////////////////////////////////
  assign tag       = addrCpu[`ADDR_W-1 -: `TAG_W];
  assign set       = addrCpu[`OFF_W+1 +: `SET_W];
  assign offCpu    = addrCpu[1 +: `OFF_W];      // bit 0 is the byte
  assign offFsm    = addrFsm[1 +: `OFF_W];
  assign setEn     = blockEnT'(1) << set;
  assign stalledEn = blockEnT'(1) << setStalled;
  assign metaEn    = metaPend ? stalledEn : setEn;  // write slot wins
  assign cpuWordEn = wordEnT'(1) << offCpu;
  assign fsmWordEn = wordEnT'(1) << offFsm;

  //////////////////////////////////////////////////////////////////////
  // hit detection
  //////////////////////////////////////////////////////////////////////
  assign req      = read | write;
  assign known    = ~metaPend | (setStalled == set);    // entry visible
  assign curMetaL = metaPend ? metaRegL : metaOutL;     // forward pending
  assign curMetaR = metaPend ? metaRegR : metaOutR;
  assign matchL   = known & curMetaL[`META_W-2] & (curMetaL[`TAG_W-1:0] == tag);
  assign matchR   = known & curMetaR[`META_W-2] & (curMetaR[`TAG_W-1:0] == tag);
  assign hitL     = req & matchL & ~metaPend;   // blocked while pending
  assign hitR     = req & matchR & ~metaPend;
  assign stallD   = req & metaPend & (~known | matchL | matchR);
  assign miss     = req & ~hitL & ~hitR & ~stallD;

  // replace left unless left was used last
  assign goLeft = ~curMetaL[`META_W-1];

  //////////////////////////////////////////////////////////////////////
  // data steering
  //////////////////////////////////////////////////////////////////////
  assign dataInL    = hitL ? dataInCpu : dataInFsm;   // cpu on hit
  assign dataInR    = hitR ? dataInCpu : dataInFsm;
  assign wordEnL    = hitL ? cpuWordEn : fsmWordEn;   // fsm on refill
  assign wordEnR    = hitR ? cpuWordEn : fsmWordEn;
  assign dataWriteL = (hitL & write) | (dataWe & goLeft);
  assign dataWriteR = (hitR & write) | (dataWe & ~goLeft);
  assign dataOutCpu = hitL ? dataOutL : dataOutR;    // valid on a hit

  //////////////////////////////////////////////////////////////////////
  // metadata update, held one cycle then written
  //////////////////////////////////////////////////////////////////////
  assign metaNewL = (hitL | (~hitR & goLeft)) ? {2'b11, tag}   // hit or install
                  : {1'b0, curMetaL[`META_W-2:0]};           // other way, lru off
  assign metaNewR = (hitR | (~hitL & ~goLeft)) ? {2'b11, tag}
                  : {1'b0, curMetaR[`META_W-2:0]};
  assign metaLoad = metaWe | hitL | hitR;       // hits already exclude stalls

  always_ff @(posedge clk) begin
    if (reset) begin
      metaPend <= 1'b0;
    end else begin
      metaPend <= metaLoad;                     // at most one cycle
    end
  end

  always_ff @(posedge clk) begin
    if (metaLoad) begin
      metaRegL   <= metaNewL;
      metaRegR   <= metaNewR;
      setStalled <= set;
    end
  end

  dataArray leftData (
    .clk(clk), .reset(reset), .dataIn(dataInL), .write(dataWriteL),
    .blockEnable(setEn), .wordEnable(wordEnL), .dataOut(dataOutL)
  );

  dataArray rightData (
    .clk(clk), .reset(reset), .dataIn(dataInR), .write(dataWriteR),
    .blockEnable(setEn), .wordEnable(wordEnR), .dataOut(dataOutR)
  );

  metaDataArray leftMeta (
    .clk(clk), .reset(reset), .dataIn(metaRegL), .write(metaPend),
    .blockEnable(metaEn), .dataOut(metaOutL)
  );

  metaDataArray rightMeta (
    .clk(clk), .reset(reset), .dataIn(metaRegR), .write(metaPend),
    .blockEnable(metaEn), .dataOut(metaOutR)
  );

endmodule

`default_nettype wire

//--- src/cacheTop.sv
`timescale 1ns/1ps
`default_nettype none

module cacheTop (
  input  wire                 clk,
  input  wire                 reset,
  input  wire cacheTypesPkg::addrT addrCpu,
  input  wire cacheTypesPkg::wordT dataInCpu,
  input  wire                 read,
  input  wire                 write,
  output cacheTypesPkg::wordT dataOutCpu,      // valid when done on a read
  output logic                busy,            // cpu holds its request
  output logic                fillActive       // refill in progress
);

  import cacheTypesPkg::*;

  addrT addrFsm;
  wordT dataInFsm;
  logic miss;
  logic stallD;
  logic dataWe;
  logic metaWe;
  logic memRead;
  addrT memAddr;
  logic memValid;
  wordT memData;
  logic memWrite;
  addrT memWriteAddr;
  wordT memWriteData;

  assign busy = miss | stallD;

  // write-through of a completed cpu write
  assign memWrite     = write & ~busy;
  assign memWriteAddr = addrCpu;
  assign memWriteData = dataInCpu;

  cacheData cache (
    .clk(clk), .reset(reset), .addrCpu(addrCpu), .addrFsm(addrFsm),
    .dataInCpu(dataInCpu), .dataInFsm(dataInFsm), .read(read), .write(write),
    .metaWe(metaWe), .dataWe(dataWe), .dataOutCpu(dataOutCpu),
    .miss(miss), .stallD(stallD)
  );

  missFsm fsm (
    .clk(clk), .reset(reset), .miss(miss), .addrCpu(addrCpu),
    .memValid(memValid), .memData(memData), .addrFsm(addrFsm),
    .dataInFsm(dataInFsm), .dataWe(dataWe), .metaWe(metaWe),
    .memRead(memRead), .memAddr(memAddr), .fillActive(fillActive)
  );

  mainMemory memory (
    .clk(clk), .reset(reset), .memRead(memRead), .memAddr(memAddr),
    .memWrite(memWrite), .memWriteAddr(memWriteAddr),
    .memWriteData(memWriteData), .memValid(memValid), .memData(memData)
  );

endmodule

`default_nettype wire

//--- src/cacheTypesPkg.sv
`default_nettype none

`include "cache_macros.svh"

// types for the address fields and the cache storage
package cacheTypesPkg;

  typedef logic [`ADDR_W-1:0] addrT;            // cpu byte address
  typedef logic [`WORD_W-1:0] wordT;            // data word

  // address fields
  typedef logic [`TAG_W-1:0]  tagT;             // addr[15:10]
  typedef logic [`SET_W-1:0]  setT;             // addr[9:4]
  typedef logic [`OFF_W-1:0]  offsetT;          // addr[3:1]

  //////////////////////////////////////////////////////////////////////
  // metadata format
  //   bit 7   : lru, 1 = most recently used
  //   bit 6   : vld
  //   bit 5-0 : tag
  //////////////////////////////////////////////////////////////////////
  typedef logic [`META_W-1:0] metaT;

  // one-hot selects into the arrays
  typedef logic [`NUM_SETS-1:0]        blockEnT;  // one bit per set
  typedef logic [`WORDS_PER_BLOCK-1:0] wordEnT;   // one bit per word

endpackage

`default_nettype wire

//--- src/cache_macros.svh
`ifndef CACHE_MACROS_SVH
`define CACHE_MACROS_SVH

//////////////////////////////////////////////////////////////////////
// address and data widths
//////////////////////////////////////////////////////////////////////
`define ADDR_W          16     // cpu byte address
`define WORD_W          16     // one data word

// address split: tag | set | word offset | byte
`define TAG_W           6      // addr[15:10]
`define SET_W           6      // addr[9:4]
`define NUM_SETS        64     // 2**SET_W
`define OFF_W           3      // addr[3:1]
`define WORDS_PER_BLOCK 8      // 2**OFF_W

// metadata byte per way per set
`define META_W          8      // lru | vld | tag

//////////////////////////////////////////////////////////////////////
// backing memory
//////////////////////////////////////////////////////////////////////
`define MEM_WORDS       32768  // full 16-bit byte space in words
`define MEM_LAT_MAX     5      // worst read latency in cycles

`endif

//--- src/dataArray.sv
`timescale 1ns/1ps
`default_nettype none

`include "cache_macros.svh"

module dataArray (
  input  wire                   clk,
  input  wire                   reset,
  input  wire cacheTypesPkg::wordT    dataIn,       // word to store
  input  wire                   write,              // store strobe
  input  wire cacheTypesPkg::blockEnT blockEnable,  // one-hot set
  input  wire cacheTypesPkg::wordEnT  wordEnable,   // one-hot word
  output cacheTypesPkg::wordT   dataOut             // selected word
);

  import cacheTypesPkg::*;

  wordT blocks [`NUM_SETS][`WORDS_PER_BLOCK];   // one way, 64 x 8 words

  // async read, or of the single selected word
  always_comb begin
    dataOut = '0;
    for (int b = 0; b < `NUM_SETS; b++) begin
      for (int w = 0; w < `WORDS_PER_BLOCK; w++) begin
        if (blockEnable[b] && wordEnable[w]) begin
          dataOut = dataOut | blocks[b][w];
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int b = 0; b < `NUM_SETS; b++) begin
        for (int w = 0; w < `WORDS_PER_BLOCK; w++) begin
          blocks[b][w] <= '0;                   // empty cache
        end
      end
    end else if (write) begin
      for (int b = 0; b < `NUM_SETS; b++) begin
        for (int w = 0; w < `WORDS_PER_BLOCK; w++) begin
          if (blockEnable[b] && wordEnable[w]) begin
            blocks[b][w] <= dataIn;             // only the enabled word
          end
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- src/mainMemory.sv
`timescale 1ns/1ps
`default_nettype none

`include "cache_macros.svh"

module mainMemory #(
  parameter logic [15:0] LAT_SEED = 16'hB5A3   // nonzero lfsr start
) (
  input  wire                 clk,
  input  wire                 reset,
  input  wire                 memRead,         // read request pulse
  input  wire cacheTypesPkg::addrT memAddr,
  input  wire                 memWrite,        // cpu write-through
  input  wire cacheTypesPkg::addrT memWriteAddr,
  input  wire cacheTypesPkg::wordT memWriteData,
  output logic                memValid,        // read answer pulse
  output cacheTypesPkg::wordT memData
);

  import cacheTypesPkg::*;

  localparam int LAT_W = $clog2(`MEM_LAT_MAX + 1);

  wordT             mem [`MEM_WORDS];           // word addressed
  logic [15:0]      lfsr;
  logic [LAT_W-1:0] latency;                    // 1 .. MEM_LAT_MAX
  logic [LAT_W-1:0] waitCnt;                    // cycles left to answer
  logic [`ADDR_W-2:0] rdAddr;
  logic             fire;

  // each word starts as its own word address
  initial begin
    for (int i = 0; i < `MEM_WORDS; i++) begin
      mem[i] = wordT'(i);
    end
  end

  assign latency = LAT_W'(lfsr % 16'(`MEM_LAT_MAX)) + 1'b1;
  assign fire    = memRead ? (latency == 1) : (waitCnt == 1);

  always_ff @(posedge clk) begin
    if (reset) begin
      lfsr     <= LAT_SEED;
      waitCnt  <= '0;
      memValid <= 1'b0;
    end else begin
      memValid <= fire;
      if (memRead) begin
        lfsr    <= {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
        waitCnt <= latency - 1'b1;
      end else if (waitCnt != 0) begin
        waitCnt <= waitCnt - 1'b1;
      end
    end
  end

  always @(posedge clk) begin
    if (memRead) begin
      rdAddr <= memAddr[`ADDR_W-1:1];
    end
    if (fire) begin
      memData <= mem[memRead ? memAddr[`ADDR_W-1:1] : rdAddr];
    end
    if (memWrite) begin
      mem[memWriteAddr[`ADDR_W-1:1]] <= memWriteData;   // single cycle
    end
  end

endmodule

`default_nettype wire

//--- src/metaDataArray.sv
`timescale 1ns/1ps
`default_nettype none

`include "cache_macros.svh"

module metaDataArray (
  input  wire                   clk,
  input  wire                   reset,
  input  wire cacheTypesPkg::metaT    dataIn,       // lru, vld, tag
  input  wire                   write,              // store strobe
  input  wire cacheTypesPkg::blockEnT blockEnable,  // one-hot set
  output cacheTypesPkg::metaT   dataOut             // entry of that set
);

  import cacheTypesPkg::*;

  metaT entries [`NUM_SETS];                    // one byte per set

  // async read of the enabled set
  always_comb begin
    dataOut = '0;
    for (int s = 0; s < `NUM_SETS; s++) begin
      if (blockEnable[s]) begin
        dataOut = dataOut | entries[s];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int s = 0; s < `NUM_SETS; s++) begin
        entries[s] <= '0;                       // vld = 0 everywhere
      end
    end else if (write) begin
      for (int s = 0; s < `NUM_SETS; s++) begin
        if (blockEnable[s]) begin
          entries[s] <= dataIn;
        end
      end
    end
  end

  // write and read share the select, so a pending write
  // shows the stalled set on dataOut for that cycle

endmodule

`default_nettype wire

//--- src/missFsm.sv
`timescale 1ns/1ps
`default_nettype none

`include "cache_macros.svh"

module missFsm (
  input  wire                 clk,
  input  wire                 reset,
  input  wire                 miss,            // from cacheData
  input  wire cacheTypesPkg::addrT addrCpu,    // missing address
  input  wire                 memValid,        // read answer pulse
  input  wire cacheTypesPkg::wordT memData,
  output cacheTypesPkg::addrT addrFsm,         // word being filled
  output cacheTypesPkg::wordT dataInFsm,
  output logic                dataWe,
  output logic                metaWe,
  output logic                memRead,         // one-cycle pulse
  output cacheTypesPkg::addrT memAddr,
  output logic                fillActive
);

  import cacheTypesPkg::*;
  import cacheCtrlPkg::*;

  fillStateT state;
  fillStateT stateNext;
  wordCountT wordCount;
  logic [`ADDR_W-1:`OFF_W+1] blockBase;         // tag and set of the block
  wordT      fillData;                          // word held for WRITE
  addrT      wordAddr;

  always_comb begin
    stateNext = state;
    case (state)
      IDLE:    if (miss) stateNext = REQ;
      REQ:     stateNext = WAIT;
      WAIT:    if (memValid) stateNext = WRITE;
      WRITE:   stateNext = (wordCount == wordCountT'(`WORDS_PER_BLOCK - 1)) ? META : REQ;
      META:    stateNext = DONE;
      DONE:    stateNext = IDLE;                // miss already low here
      default: stateNext = IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state     <= IDLE;
      wordCount <= '0;
    end else begin
      state <= stateNext;
      if (state == IDLE) begin
        wordCount <= '0;
      end else if (state == WRITE) begin
        wordCount <= wordCount + 1'b1;          // wraps to 0 after word 7
      end
    end
  end

  // block address and refill word
  always_ff @(posedge clk) begin
    if (state == IDLE && miss) begin
      blockBase <= addrCpu[`ADDR_W-1:`OFF_W+1];
    end
    if (state == WAIT && memValid) begin
      fillData <= memData;
    end
  end

  assign wordAddr   = {blockBase, wordCount, 1'b0};
  assign addrFsm    = wordAddr;
  assign memAddr    = wordAddr;
  assign dataInFsm  = fillData;
  assign memRead    = (state == REQ);
  assign dataWe     = (state == WRITE);
  assign metaWe     = (state == META);
  assign fillActive = (state != IDLE) && (state != DONE);

endmodule

`default_nettype wire
